//--- hw/snd_pkg.sv
// ##########################################################################
// FRAME_LEN must be a whole multiple of FM_DIV and PSG_DIV so that the enables stay aligned
// ##########################################################################

package snd_pkg;

    // ######################################################################
    // Sample widths
    // ######################################################################
    localparam int FM_W  = 16;                          // FM synthesizer sample width
    localparam int PSG_W = 12;                          // Tone generator sample width
    localparam int OUT_W = 16;                          // Mixed output sample width

    // ######################################################################
    // Rates, all counted in clk cycles
    // ######################################################################
    localparam int FM_DIV    = 4;                       // One FM input sample every 4 clocks
    localparam int PSG_DIV   = 2;                       // One PSG input sample every 2 clocks
    localparam int FRAME_LEN = 24;                      // One output sample every 24 clocks
    localparam int FRAME_CNT_W = $clog2(FRAME_LEN);     // Width of the frame counter

    // ######################################################################
    // Filter growth and mixing
    // ######################################################################
    localparam int FM_GROWTH  = 6;                      // 2**6 covers the FM gain of 6*6
    localparam int PSG_GROWTH = 8;                      // 2**8 covers the PSG gain of 12*12
    localparam int PSG_SHIFT  = 4;                      // Lifts 12-bit PSG to 16-bit scale

    // Mixer sum keeps one spare bit above the widest operand
    localparam int MIX_W = ((FM_W > PSG_W + PSG_SHIFT) ? FM_W : PSG_W + PSG_SHIFT) > OUT_W
                         ? ((FM_W > PSG_W + PSG_SHIFT) ? FM_W : PSG_W + PSG_SHIFT) + 1
                         : OUT_W + 1;

    // Clamp limits of the output, held at mixer width
    localparam logic signed [MIX_W-1:0] OUT_MAX = MIX_W'((64'sd1 <<< (OUT_W - 1)) - 1);
    localparam logic signed [MIX_W-1:0] OUT_MIN = ~OUT_MAX;

    // ######################################################################
    // Sample types
    // ######################################################################
    typedef logic signed [FM_W-1:0]  fm_sample_t;       // FM stream sample
    typedef logic signed [PSG_W-1:0] psg_sample_t;      // PSG stream sample
    typedef logic signed [OUT_W-1:0] out_sample_t;      // Mixed output sample

endpackage

//--- hw/snd_cen_gen.sv
// ##########################################################################
// Enables lag the frame counter by one clock, so all are low right after reset
// ##########################################################################

module snd_cen_gen
    import snd_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output logic cen_fm,                                // FM input sample enable
    output logic cen_psg,                               // PSG input sample enable
    output logic cen_out                                // Output sample enable
);

    // ######################################################################
    // Frame counter
    // ######################################################################
    logic [FRAME_CNT_W-1:0] cnt;                        // Position inside the output frame
    logic                   cnt_wrap;                   // Last clock of the frame

    assign cnt_wrap = (cnt == FRAME_CNT_W'(FRAME_LEN - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;                                  // Frame starts at position 0
        end else if (cnt_wrap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // ######################################################################
    // Enable decode
    // ######################################################################
    // All three enables are high together at frame position 0, which keeps
    // both input rates exact integer multiples of the output rate
    always_ff @(posedge clk) begin
        if (rst) begin
            cen_fm  <= 1'b0;
            cen_psg <= 1'b0;
            cen_out <= 1'b0;
        end else begin
            cen_fm  <= (int'(cnt) % FM_DIV) == 0;       // Every FM_DIV clocks
            cen_psg <= (int'(cnt) % PSG_DIV) == 0;      // Every PSG_DIV clocks
            cen_out <= (cnt == '0);                     // Once per frame
        end
    end

endmodule

//--- hw/cic_decim.sv
// ##########################################################################
// DC gain is ratio**2 / 2**GROWTH, output is the comb result truncated to its top bits
// ##########################################################################

module cic_decim
    import snd_pkg::*;
#(
    parameter type sample_t = fm_sample_t,              // Sample type of this stream
    parameter int  GROWTH   = FM_GROWTH                 // Extra integrator bits
)
(
    input  logic    clk,
    input  logic    rst,
    input  logic    cen_in,                             // Input sample rate
    input  logic    cen_out,                            // Output sample rate
    input  sample_t snd_in,
    output sample_t snd_out
);

    localparam int IN_W  = $bits(sample_t);             // Width of one sample
    localparam int ACC_W = IN_W + GROWTH;               // Width of integrators and combs

    typedef logic signed [ACC_W-1:0] acc_t;

    // ######################################################################
    // Integrators at the input rate
    // ######################################################################
    acc_t integ1, integ2;                               // Integrator registers
    acc_t integ1_nxt, integ2_nxt;                       // Values after this clock

    // The comb side reads the next values so that an input taken in the
    // same clock as cen_out is already part of the frame it closes
    always_comb begin
        integ1_nxt = integ1;
        integ2_nxt = integ2;
        if (cen_in) begin
            integ1_nxt = integ1 + acc_t'(snd_in);       // Sign extended, wraps freely
            integ2_nxt = integ2 + integ1;               // Second stage sees the old first
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            integ1 <= '0;
            integ2 <= '0;
        end else begin
            integ1 <= integ1_nxt;
            integ2 <= integ2_nxt;
        end
    end

    // ######################################################################
    // Combs at the output rate
    // ######################################################################
    acc_t last, comb1, last_comb1;                      // Comb delay lines
    acc_t comb2;                                        // Second comb difference

    assign comb2 = comb1 - last_comb1;

    always_ff @(posedge clk) begin
        if (rst) begin
            last       <= '0;
            comb1      <= '0;
            last_comb1 <= '0;
            snd_out    <= '0;
        end else if (cen_out) begin
            last       <= integ2_nxt;                   // Keep this frame for the next
            comb1      <= integ2_nxt - last;            // First difference
            last_comb1 <= comb1;
            snd_out    <= sample_t'(comb2[ACC_W-1 -: IN_W]); // Drop the growth bits
        end
    end

endmodule

//--- hw/snd_mix.sv
// ##########################################################################
// Output saturates at the out_sample_t limits; snd holds until the next strobe
// ##########################################################################

module snd_mix
    import snd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen_out,                        // Output rate the decimators update on
    input  fm_sample_t  fm_dec,                         // Decimated FM sample
    input  psg_sample_t psg_dec,                        // Decimated PSG sample
    output out_sample_t snd,                            // Mixed sample
    output logic        snd_stb                         // High for one clock per new sample
);

    // ######################################################################
    // Full precision sum and clamp
    // ######################################################################
    logic signed [MIX_W-1:0] fm_ext;                    // FM at mixer width
    logic signed [MIX_W-1:0] psg_ext;                   // PSG at mixer width and scaled up
    logic signed [MIX_W-1:0] mix_sum;                   // Sum before clamping
    out_sample_t             mix_sat;                   // Sum after clamping

    assign fm_ext  = MIX_W'(fm_dec);
    assign psg_ext = MIX_W'(psg_dec) <<< PSG_SHIFT;     // Brings PSG to FM scale
    assign mix_sum = fm_ext + psg_ext;

    always_comb begin
        if (mix_sum > OUT_MAX) begin
            mix_sat = out_sample_t'(OUT_MAX);           // Clip at the positive limit
        end else if (mix_sum < OUT_MIN) begin
            mix_sat = out_sample_t'(OUT_MIN);           // Clip at the negative limit
        end else begin
            mix_sat = out_sample_t'(mix_sum);
        end
    end

    // ######################################################################
    // Output register and strobe
    // ######################################################################
    logic cen_d;                                        // cen_out one clock later

    // The decimators update on cen_out, so their new samples are valid in
    // the clock after it, and snd and snd_stb both change at the end of that clock
    always_ff @(posedge clk) begin
        if (rst) begin
            cen_d   <= 1'b0;
            snd_stb <= 1'b0;
            snd     <= '0;
        end else begin
            cen_d   <= cen_out;
            snd_stb <= cen_d;                           // Single clock like cen_out
            if (cen_d) begin
                snd <= mix_sat;
            end
        end
    end

endmodule

//--- hw/snd_decim_top.sv
// ##########################################################################
// Sources must present a new sample whenever cen_fm or cen_psg is high
// ##########################################################################

module snd_decim_top
    import snd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fm_sample_t  fm_snd,                         // FM synthesizer stream
    input  psg_sample_t psg_snd,                        // Tone generator stream
    output logic        cen_fm,                         // Asks the FM source for a sample
    output logic        cen_psg,                        // Asks the PSG source for a sample
    output out_sample_t snd,                            // Mixed sample at the output rate
    output logic        snd_stb                         // Marks each new mixed sample
);

    logic        cen_out;                               // Output rate enable
    fm_sample_t  fm_dec;                                // FM after decimation
    psg_sample_t psg_dec;                               // PSG after decimation

    // ######################################################################
    // Rate generation
    // ######################################################################
    snd_cen_gen u_cen (
        .clk     (clk),
        .rst     (rst),
        .cen_fm  (cen_fm),
        .cen_psg (cen_psg),
        .cen_out (cen_out)
    );

    // ######################################################################
    // Decimators, one per stream, both closing on cen_out
    // ######################################################################
    cic_decim #(.sample_t(fm_sample_t), .GROWTH(FM_GROWTH)) u_fm (
        .clk     (clk),
        .rst     (rst),
        .cen_in  (cen_fm),
        .cen_out (cen_out),
        .snd_in  (fm_snd),
        .snd_out (fm_dec)
    );

    cic_decim #(.sample_t(psg_sample_t), .GROWTH(PSG_GROWTH)) u_psg (
        .clk     (clk),
        .rst     (rst),
        .cen_in  (cen_psg),
        .cen_out (cen_out),
        .snd_in  (psg_snd),
        .snd_out (psg_dec)
    );

    // Mixing and output strobe
    snd_mix u_mix (
        .clk     (clk),
        .rst     (rst),
        .cen_out (cen_out),
        .fm_dec  (fm_dec),
        .psg_dec (psg_dec),
        .snd     (snd),
        .snd_stb (snd_stb)
    );

endmodule

//--- verif/snd_decim_chk.sv
// ##########################################################################
// Timing rules of the enables and the output strobe, checked outside reset
// ##########################################################################

module snd_decim_chk (
    input logic clk,
    input logic rst,
    input logic cen_fm,                                         // FM input enable
    input logic cen_psg,                                        // PSG input enable
    input logic cen_out,                                        // Internal output enable
    input logic snd_stb                                         // Mixed sample strobe
);

    timeunit 1ns;
    timeprecision 1ps;

    // ######################################################################
    // Strobe shape and position
    // ######################################################################
    a_stb_single: assert property (@(posedge clk) disable iff (rst)
        snd_stb |=> !snd_stb)                                   // One clock per sample
        else $error("snd_stb stayed high for two clocks");

    a_stb_delay: assert property (@(posedge clk) disable iff (rst)
        snd_stb == $past(cen_out, 2))                           // Mixer register plus load
        else $error("snd_stb is not two clocks after cen_out");

    // ######################################################################
    // Enable alignment
    // ######################################################################
    a_cen_aligned: assert property (@(posedge clk) disable iff (rst)
        cen_out |-> (cen_fm && cen_psg))                        // Frames close on input samples
        else $error("cen_out came without cen_fm and cen_psg");

endmodule

//--- verif/snd_decim_tb.sv
// ##########################################################################
// Expected samples come from a cycle model of the enable, CIC and mixer rules
// A missing snd_stb stops the run after 100 clocks
// ##########################################################################

module snd_decim_tb
    import snd_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int     RST_CYCLES    = 4;                       // Reset length in clocks
    localparam int     STB_TIMEOUT   = 100;                     // Longest wait for a strobe
    localparam int     SETTLE_FRAMES = 8;                       // Frames for a step to settle
    localparam longint OUT_HI = (longint'(1) <<< (OUT_W - 1)) - 1;
    localparam longint OUT_LO = -(longint'(1) <<< (OUT_W - 1));

    logic        clk = 1'b0;
    logic        rst;
    fm_sample_t  fm_snd;
    psg_sample_t psg_snd;
    logic        cen_fm;
    logic        cen_psg;
    out_sample_t snd;
    logic        snd_stb;

    int          seed = 58861;                                  // Seed for $random
    int          cyc = 0;                                       // Clock counter
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    bit          cad_on = 1'b0;                                 // Strobe cadence window open
    int          cad_count = 0;                                 // Strobes seen in the window
    out_sample_t exp_snd;                                       // Model output for this cycle

    // ######################################################################
    // DUT, clock and bound checker
    // ######################################################################
    snd_decim_top DUT (
        .clk     (clk),
        .rst     (rst),
        .fm_snd  (fm_snd),
        .psg_snd (psg_snd),
        .cen_fm  (cen_fm),
        .cen_psg (cen_psg),
        .snd     (snd),
        .snd_stb (snd_stb)
    );

    bind snd_decim_top snd_decim_chk u_chk (
        .clk     (clk),
        .rst     (rst),
        .cen_fm  (cen_fm),
        .cen_psg (cen_psg),
        .cen_out (cen_out),
        .snd_stb (snd_stb)
    );

    always #5 clk = ~clk;                                       // 10 ns period
    always @(posedge clk) cyc <= cyc + 1;

    // ######################################################################
    // Reference model with index 0 for the FM stream and index 1 for the PSG stream
    // ######################################################################
    int     m_cnt;                                              // Model frame counter
    bit     m_cen_fm;
    bit     m_cen_psg;
    bit     m_cen_out;
    bit     m_cen_d;                                            // Mixer load enable
    longint m_i1 [2];                                           // First integrators
    longint m_i2 [2];                                           // Second integrators
    longint m_last [2];                                         // Integrator value of last frame
    longint m_c1 [2];                                           // First comb results
    longint m_lc1 [2];                                          // Previous first comb results
    longint m_dec [2];                                          // Decimated samples
    longint m_snd;                                              // Mixed sample

    function automatic longint wrap_to(longint v, int w);
        return (v <<< (64 - w)) >>> (64 - w);                   // Two's complement wrap at w bits
    endfunction

    function automatic longint clamp_out(longint v);
        if (v > OUT_HI) begin
            return OUT_HI;
        end
        if (v < OUT_LO) begin
            return OUT_LO;
        end
        return v;
    endfunction

    // Advances the model by one clock and returns the expected snd after it
    function automatic out_sample_t decim_model(logic r, fm_sample_t fm_x, psg_sample_t psg_x);
        longint x [2];
        bit     cen_in [2];
        int     acc_w [2];
        int     grow [2];
        longint i2_nxt;
        if (r) begin
            m_cnt     = 0;
            m_cen_fm  = 1'b0;
            m_cen_psg = 1'b0;
            m_cen_out = 1'b0;
            m_cen_d   = 1'b0;
            m_snd     = 0;
            for (int s = 0; s < 2; s++) begin
                m_i1[s]   = 0;
                m_i2[s]   = 0;
                m_last[s] = 0;
                m_c1[s]   = 0;
                m_lc1[s]  = 0;
                m_dec[s]  = 0;
            end
            return '0;
        end
        x[0]      = longint'(fm_x);
        x[1]      = longint'(psg_x);
        cen_in[0] = m_cen_fm;
        cen_in[1] = m_cen_psg;
        acc_w[0]  = FM_W + FM_GROWTH;
        acc_w[1]  = PSG_W + PSG_GROWTH;
        grow[0]   = FM_GROWTH;
        grow[1]   = PSG_GROWTH;
        if (m_cen_d) begin                                      // Mixer sees the held samples
            m_snd = clamp_out(m_dec[0] + (m_dec[1] <<< PSG_SHIFT));
        end
        m_cen_d = m_cen_out;
        for (int s = 0; s < 2; s++) begin
            i2_nxt = m_i2[s];
            if (cen_in[s]) begin
                i2_nxt  = wrap_to(m_i2[s] + m_i1[s], acc_w[s]); // Uses the old first stage
                m_i1[s] = wrap_to(m_i1[s] + x[s], acc_w[s]);
            end
            m_i2[s] = i2_nxt;
            if (m_cen_out) begin
                m_dec[s]  = wrap_to(m_c1[s] - m_lc1[s], acc_w[s]) >>> grow[s]; // Top bits
                m_lc1[s]  = m_c1[s];
                m_c1[s]   = wrap_to(i2_nxt - m_last[s], acc_w[s]);
                m_last[s] = i2_nxt;
            end
        end
        m_cen_fm  = (m_cnt % FM_DIV) == 0;                      // Enables lag the counter
        m_cen_psg = (m_cnt % PSG_DIV) == 0;
        m_cen_out = (m_cnt == 0);
        m_cnt     = (m_cnt == FRAME_LEN - 1) ? 0 : m_cnt + 1;
        return out_sample_t'(m_snd);
    endfunction

    // Closed form of a settled constant input with a gain of ratio squared over the growth
    function automatic out_sample_t settled_mix(longint fm_x, longint psg_x);
        longint fm_r;
        longint psg_r;
        fm_r  = FRAME_LEN / FM_DIV;
        psg_r = FRAME_LEN / PSG_DIV;
        return out_sample_t'(clamp_out(((fm_x * fm_r * fm_r) >>> FM_GROWTH)
                                       + (((psg_x * psg_r * psg_r) >>> PSG_GROWTH) <<< PSG_SHIFT)));
    endfunction

    always @(posedge clk) exp_snd = decim_model(rst, fm_snd, psg_snd);

    // ######################################################################
    // Checks and reporting
    // ######################################################################
    task automatic compare_sample(string name, out_sample_t act, out_sample_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic compare_count(string name, int act, int exp);
        checks++;
        if (act != exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic compare_enable(string name, logic act, logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %0b, got %0b", $time, name, exp, act);
        end
    endtask

    task automatic report_test(string name, int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    // Source enables follow the model frame counter in every clock
    always @(negedge clk) begin
        compare_enable("cen_fm", cen_fm, m_cen_fm);
        compare_enable("cen_psg", cen_psg, m_cen_psg);
    end

    task automatic hold_inputs(fm_sample_t fm_v, psg_sample_t psg_v, int frames);
        @(posedge clk);
        fm_snd  <= fm_v;
        psg_snd <= psg_v;
        repeat (frames * FRAME_LEN) @(posedge clk);
    endtask

    // Every strobed sample is checked against the model at the falling edge
    initial begin : compare_proc
        int wait_cyc;
        int last_stb_cyc;
        bit stb_seen;
        last_stb_cyc = -1;
        stb_seen     = 1'b1;
        while (stb_seen) begin
            wait_cyc = 0;
            @(negedge clk);
            while (!snd_stb && wait_cyc < STB_TIMEOUT) begin
                @(negedge clk);
                wait_cyc++;
            end
            stb_seen = (snd_stb === 1'b1);
            if (stb_seen) begin
                compare_sample("snd", snd, exp_snd);
                if (cad_on) begin
                    cad_count++;
                    compare_count("snd_stb gap", cyc - last_stb_cyc, FRAME_LEN);
                end
                last_stb_cyc = cyc;
            end
        end
        $display("Timeout: no snd_stb within %0d clocks at %0t", STB_TIMEOUT, $time);
        $display("=== FAIL ===");
        $finish;
    end

    // ######################################################################
    // Stimulus
    // ######################################################################
    initial begin : main_proc
        int err_mark;
        rst     = 1'b1;
        fm_snd  = '0;
        psg_snd = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        err_mark = errors;
        @(negedge clk);
        compare_sample("snd", snd, '0);                         // Cleared by reset
        hold_inputs('0, '0, 4);
        @(negedge clk);
        compare_sample("snd", snd, '0);
        report_test("reset and zero input", err_mark);

        err_mark = errors;
        hold_inputs(16'sd1000, '0, SETTLE_FRAMES);
        @(negedge clk);
        compare_sample("snd", snd, settled_mix(1000, 0));       // 1000 * 36 / 64
        report_test("FM step", err_mark);

        err_mark = errors;
        hold_inputs('0, 12'sd500, SETTLE_FRAMES);
        @(negedge clk);
        compare_sample("snd", snd, settled_mix(0, 500));        // (500 * 144 / 256) * 16
        report_test("PSG step", err_mark);

        err_mark = errors;
        hold_inputs(16'sd32767, 12'sd2047, SETTLE_FRAMES);
        @(negedge clk);
        compare_sample("snd", snd, out_sample_t'(OUT_HI));
        hold_inputs(-16'sd32768, -12'sd2048, SETTLE_FRAMES);
        @(negedge clk);
        compare_sample("snd", snd, out_sample_t'(OUT_LO));
        report_test("saturation", err_mark);

        err_mark = errors;
        repeat (200 * FRAME_LEN) begin
            @(posedge clk);
            fm_snd  <= fm_sample_t'($random(seed));
            psg_snd <= psg_sample_t'($random(seed));
        end
        report_test("random streams", err_mark);

        err_mark = errors;
        hold_inputs('0, '0, 1);
        cad_count = 0;
        cad_on    = 1'b1;                                       // Window of exactly 50 frames
        repeat (50 * FRAME_LEN) @(posedge clk);
        cad_on = 1'b0;
        compare_count("snd_stb count", cad_count, 50);
        report_test("strobe cadence", err_mark);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- flist.f
hw/snd_pkg.sv
hw/snd_cen_gen.sv
hw/cic_decim.sv
hw/snd_mix.sv
hw/snd_decim_top.sv
verif/snd_decim_chk.sv
verif/snd_decim_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
# Returns 0 only when the run finished and the log holds no failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
MDIR=obj_dir
EXE=snd_decim_sim

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module snd_decim_tb \
    --Mdir "$MDIR" \
    -o "$EXE"
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status"
    exit 1
fi

"./$MDIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "=== PASS ===" "$LOG"; then
    echo "Simulation did not reach its end"
    exit 1
fi

echo "Simulation passed"
exit 0
